/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rect_draw_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* src/cmd_mailbox.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rect_defines.svh"

module cmd_mailbox (
	input  wire               iCLK,
	// Host port
	input  rect_pkg::mb_addr_t host_addr,
	input  rect_pkg::word_t    host_wdata,
	input  wire               host_we,
	output rect_pkg::word_t    host_rdata,
	// Engine port
	input  rect_pkg::mb_addr_t eng_addr,
	input  rect_pkg::word_t    eng_wdata,
	input  wire               eng_we,
	output rect_pkg::word_t    eng_rdata
);

	// ============================================================
	// Storage
	// ============================================================
	// Shared command words, contents survive reset
	rect_pkg::word_t mem [`MB_DEPTH];

	// Both ports hitting the same word with a write
	logic collide;

	assign collide = host_we && eng_we && (host_addr == eng_addr);

	// ============================================================
	// Write and registered read
	// ============================================================
	always_ff @(posedge iCLK) begin
		// Host owns the word on a collision
		if (eng_we && !collide) begin
			mem[eng_addr] <= eng_wdata;
		end
		if (host_we) begin
			mem[host_addr] <= host_wdata;
		end

		// Read data lags the address by one cycle
		// Old contents on a read during write
		host_rdata <= mem[host_addr];
		eng_rdata  <= mem[eng_addr];
	end

endmodule

`default_nettype wire

/* src/cmd_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rect_defines.svh"

module cmd_sequencer (
	input  wire                iCLK,
	input  wire                rst,
	// Engine side of the mailbox
	output rect_pkg::mb_addr_t eng_addr,
	output rect_pkg::word_t    eng_wdata,
	output logic               eng_we,
	input  rect_pkg::word_t    eng_rdata,
	// Four-phase handshake to the filler
	output logic               fill_req,
	input  wire                fill_ack,
	// Rectangle parameters, stable while fill_req is high
	output rect_pkg::coord_t   x1,
	output rect_pkg::coord_t   y1,
	output rect_pkg::coord_t   x2,
	output rect_pkg::coord_t   y2,
	output rect_pkg::color_t   color
);

	// ============================================================
	// State
	// ============================================================
	rect_pkg::seq_state_t state;

	// Word index of the parameter being fetched
	rect_pkg::mb_addr_t fetch_idx;

	// Only value the engine ever writes back is the cleared flag
	assign eng_wdata = '0;

	// ============================================================
	// Sequencer FSM
	// ============================================================
	always_ff @(posedge iCLK) begin
		if (rst) begin
			state     <= rect_pkg::POLL_ADDR;
			eng_addr  <= rect_pkg::mb_addr_t'(`MB_FLAG);
			eng_we    <= 1'b0;
			fill_req  <= 1'b0;
			fetch_idx <= rect_pkg::mb_addr_t'(`MB_X1);
		end else begin
			// Write strobe lasts a single cycle
			eng_we <= 1'b0;

			case (state)
				// Point the engine port at the flag word
				rect_pkg::POLL_ADDR: begin
					eng_addr <= rect_pkg::mb_addr_t'(`MB_FLAG);
					state    <= rect_pkg::POLL_WAIT;
				end

				// RAM read in flight
				rect_pkg::POLL_WAIT: begin
					state <= rect_pkg::POLL_TEST;
				end

				// Flag word on eng_rdata now
				rect_pkg::POLL_TEST: begin
					if (eng_rdata != '0) begin
						fetch_idx <= rect_pkg::mb_addr_t'(`MB_X1);
						state     <= rect_pkg::FETCH_ADDR;
					end else begin
						state <= rect_pkg::POLL_ADDR;
					end
				end

				rect_pkg::FETCH_ADDR: begin
					eng_addr <= fetch_idx;
					state    <= rect_pkg::FETCH_WAIT;
				end

				rect_pkg::FETCH_WAIT: begin
					state <= rect_pkg::FETCH_CAPTURE;
				end

				// Keep the low bits of each parameter word
				rect_pkg::FETCH_CAPTURE: begin
					case (fetch_idx)
						rect_pkg::mb_addr_t'(`MB_X1): x1 <= eng_rdata[`COORD_W-1:0];
						rect_pkg::mb_addr_t'(`MB_Y1): y1 <= eng_rdata[`COORD_W-1:0];
						rect_pkg::mb_addr_t'(`MB_X2): x2 <= eng_rdata[`COORD_W-1:0];
						rect_pkg::mb_addr_t'(`MB_Y2): y2 <= eng_rdata[`COORD_W-1:0];
						default: color <= eng_rdata[`COLOR_W-1:0];
					endcase

					// Colour is the last word, then hand off
					if (fetch_idx == rect_pkg::mb_addr_t'(`MB_COLOR)) begin
						fill_req <= 1'b1;
						state    <= rect_pkg::HANDOFF;
					end else begin
						fetch_idx <= fetch_idx + rect_pkg::mb_addr_t'(1);
						state     <= rect_pkg::FETCH_ADDR;
					end
				end

				// Filler is drawing, wait for its ack
				rect_pkg::HANDOFF: begin
					if (fill_ack) begin
						fill_req <= 1'b0;
						state    <= rect_pkg::RELEASE;
					end
				end

				// Ack must drop before the flag is cleared
				rect_pkg::RELEASE: begin
					if (!fill_ack) begin
						eng_addr <= rect_pkg::mb_addr_t'(`MB_FLAG);
						eng_we   <= 1'b1;
						state    <= rect_pkg::CLEAR_FLAG;
					end
				end

				// Zero lands in word 0 at the end of this cycle
				rect_pkg::CLEAR_FLAG: begin
					state <= rect_pkg::POLL_ADDR;
				end

				default: begin
					state <= rect_pkg::POLL_ADDR;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/rect_defines.svh */
`ifndef RECT_DEFINES_SVH
`define RECT_DEFINES_SVH

// ============================================================
// Screen geometry
// ============================================================
// Pixels per row of the frame buffer
`define SCREEN_WIDTH 640
// Covers 640 x 480 pixels
`define FB_ADDR_W    19
`define COORD_W      10
`define COLOR_W      8

// ============================================================
// Mailbox layout
// ============================================================
`define MB_DEPTH     256
`define MB_ADDR_W    8
`define WORD_W       32
// Word 0 holds the command flag, nonzero means a command is pending
`define MB_FLAG      0
`define MB_X1        1
`define MB_Y1        2
`define MB_X2        3
`define MB_Y2        4
`define MB_COLOR     5

`endif

/* src/rect_draw_top.sv */
`timescale 1ns/1ns
`default_nettype none

module rect_draw_top (
	input  wire                iCLK,
	input  wire                rst,
	// Host mailbox port
	input  rect_pkg::mb_addr_t host_addr,
	input  rect_pkg::word_t    host_wdata,
	input  wire                host_we,
	output rect_pkg::word_t    host_rdata,
	// Frame-buffer write port
	output wire                fb_we,
	output rect_pkg::fb_addr_t fb_addr,
	output rect_pkg::color_t   fb_data
);

	// ============================================================
	// Internal nets
	// ============================================================
	rect_pkg::mb_addr_t eng_addr;
	rect_pkg::word_t    eng_wdata;
	wire                eng_we;
	rect_pkg::word_t    eng_rdata;

	// Sequencer to filler handshake and parameters
	wire                fill_req;
	wire                fill_ack;
	rect_pkg::coord_t   x1;
	rect_pkg::coord_t   y1;
	rect_pkg::coord_t   x2;
	rect_pkg::coord_t   y2;
	rect_pkg::color_t   color;

	cmd_mailbox u_mailbox (
		.iCLK       (iCLK),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_we    (host_we),
		.host_rdata (host_rdata),
		.eng_addr   (eng_addr),
		.eng_wdata  (eng_wdata),
		.eng_we     (eng_we),
		.eng_rdata  (eng_rdata)
	);

	cmd_sequencer u_sequencer (
		.iCLK      (iCLK),
		.rst       (rst),
		.eng_addr  (eng_addr),
		.eng_wdata (eng_wdata),
		.eng_we    (eng_we),
		.eng_rdata (eng_rdata),
		.fill_req  (fill_req),
		.fill_ack  (fill_ack),
		.x1        (x1),
		.y1        (y1),
		.x2        (x2),
		.y2        (y2),
		.color     (color)
	);

	// Draws one pixel per clock into the frame buffer
	rect_filler u_filler (
		.iCLK     (iCLK),
		.rst      (rst),
		.fill_req (fill_req),
		.fill_ack (fill_ack),
		.x1       (x1),
		.y1       (y1),
		.x2       (x2),
		.y2       (y2),
		.color    (color),
		.fb_we    (fb_we),
		.fb_addr  (fb_addr),
		.fb_data  (fb_data)
	);

endmodule

`default_nettype wire

/* src/rect_filler.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rect_defines.svh"

module rect_filler (
	input  wire              iCLK,
	input  wire              rst,
	// Four-phase handshake from the sequencer
	input  wire              fill_req,
	output logic             fill_ack,
	input  rect_pkg::coord_t x1,
	input  rect_pkg::coord_t y1,
	input  rect_pkg::coord_t x2,
	input  rect_pkg::coord_t y2,
	input  rect_pkg::color_t color,
	// Frame-buffer write port, no back-pressure
	output logic             fb_we,
	output rect_pkg::fb_addr_t fb_addr,
	output rect_pkg::color_t fb_data
);

	// ============================================================
	// Walk position
	// ============================================================
	rect_pkg::fill_state_t state;
	rect_pkg::coord_t      col;
	rect_pkg::coord_t      row;

	// Pixel issued this cycle
	rect_pkg::coord_t      cur_col;
	rect_pkg::coord_t      cur_row;
	logic                  issue;
	logic                  last_pix;

	// First pixel comes straight from the corner inputs
	assign cur_col = (state == rect_pkg::IDLE) ? x1 : col;
	assign cur_row = (state == rect_pkg::IDLE) ? y1 : row;

	assign issue    = ((state == rect_pkg::IDLE) && fill_req) || (state == rect_pkg::WALK);
	// End rule, also covers x1 > x2
	assign last_pix = (cur_col >= x2) && (cur_row >= y2);

	// ============================================================
	// Filler FSM
	// ============================================================
	always_ff @(posedge iCLK) begin
		if (rst) begin
			state    <= rect_pkg::IDLE;
			fb_we    <= 1'b0;
			fill_ack <= 1'b0;
		end else begin
			fb_we <= issue;

			if (issue) begin
				// Raster step
				if (cur_col < x2) begin
					col <= cur_col + rect_pkg::coord_t'(1);
					row <= cur_row;
				end else begin
					col <= x1;
					row <= cur_row + rect_pkg::coord_t'(1);
				end
				state <= last_pix ? rect_pkg::DONE : rect_pkg::WALK;
			end

			// Hold ack until the sequencer lets go of req
			if (state == rect_pkg::DONE) begin
				if (!fill_req) begin
					fill_ack <= 1'b0;
					state    <= rect_pkg::IDLE;
				end else begin
					fill_ack <= 1'b1;
				end
			end
		end
	end

	// Write payload, y * 640 + x
	always_ff @(posedge iCLK) begin
		if (issue) begin
			fb_addr <= rect_pkg::fb_addr_t'(cur_row) * rect_pkg::fb_addr_t'(`SCREEN_WIDTH)
				+ rect_pkg::fb_addr_t'(cur_col);
			fb_data <= color;
		end
	end

endmodule

`default_nettype wire

/* src/rect_pkg.sv */
`default_nettype none

`include "rect_defines.svh"

package rect_pkg;

	// Vector types for the widths used across the design
	typedef logic [`WORD_W-1:0]    word_t;
	typedef logic [`MB_ADDR_W-1:0] mb_addr_t;
	typedef logic [`COORD_W-1:0]   coord_t;
	typedef logic [`COLOR_W-1:0]   color_t;
	typedef logic [`FB_ADDR_W-1:0] fb_addr_t;

	// Command sequencer states
	// Poll and fetch each take three cycles
	typedef enum logic [3:0] {
		POLL_ADDR,
		POLL_WAIT,
		POLL_TEST,
		FETCH_ADDR,
		FETCH_WAIT,
		FETCH_CAPTURE,
		HANDOFF,
		RELEASE,
		CLEAR_FLAG
	} seq_state_t;

	// Rectangle filler states
	typedef enum logic [1:0] {
		IDLE,
		WALK,
		DONE
	} fill_state_t;

endpackage

`default_nettype wire

/* verif/rect_draw_assert.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rect_defines.svh"

module rect_draw_assert (
	input wire                iCLK,
	input wire                rst,
	input wire                fb_we,
	input wire                fill_req,
	input wire                fill_ack,
	input wire                eng_we,
	input rect_pkg::mb_addr_t eng_addr,
	input rect_pkg::word_t    eng_wdata
);

	// ============================================================
	// Handshake and write rules
	// ============================================================
	// Pixels only inside an open request
	a_fb_we_in_req: assert property (@(posedge iCLK) disable iff (rst)
		fb_we |-> fill_req)
		else $error("fb_we high without fill_req");

	// Ack may outlive req by one cycle
	a_ack_follows_req: assert property (@(posedge iCLK) disable iff (rst)
		fill_ack |-> (fill_req || $past(fill_req)))
		else $error("fill_ack high outside the four-phase exchange");

	// New req only once ack has dropped
	a_req_after_ack_low: assert property (@(posedge iCLK) disable iff (rst)
		$rose(fill_req) |-> !fill_ack)
		else $error("fill_req rose while fill_ack was still high");

	// Engine only ever clears the flag
	a_eng_clear_only: assert property (@(posedge iCLK) disable iff (rst)
		eng_we |-> (eng_addr == rect_pkg::mb_addr_t'(`MB_FLAG) && eng_wdata == '0))
		else $error("engine write other than a flag clear");

endmodule

bind rect_draw_top rect_draw_assert u_assert (
	.iCLK      (iCLK),
	.rst       (rst),
	.fb_we     (fb_we),
	.fill_req  (fill_req),
	.fill_ack  (fill_ack),
	.eng_we    (eng_we),
	.eng_addr  (eng_addr),
	.eng_wdata (eng_wdata)
);

`default_nettype wire

/* verif/rect_draw_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rect_defines.svh"

module rect_draw_tb;

	// ============================================================
	// Stimulus table
	// ============================================================
	localparam int NUM_CMDS    = 7;
	localparam int IDLE_CYCLES = 400;

	// Corners and colour per command, colour ignored where LFSR is used
	rect_pkg::coord_t tab_x1 [NUM_CMDS] = '{10'd10, 10'd100, 10'd50, 10'd630, 10'd0, 10'd300, 10'd7};
	rect_pkg::coord_t tab_y1 [NUM_CMDS] = '{10'd5, 10'd200, 10'd20, 10'd470, 10'd0, 10'd10, 10'd7};
	rect_pkg::coord_t tab_x2 [NUM_CMDS] = '{10'd17, 10'd100, 10'd45, 10'd639, 10'd3, 10'd331, 10'd9};
	rect_pkg::coord_t tab_y2 [NUM_CMDS] = '{10'd8, 10'd200, 10'd24, 10'd479, 10'd2, 10'd12, 10'd7};
	rect_pkg::color_t tab_color [NUM_CMDS] = '{8'h3C, 8'hA5, 8'h0F, 8'h00, 8'h00, 8'h00, 8'hFF};
	bit tab_use_lfsr [NUM_CMDS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0};

	// DUT inputs and outputs
	logic               iCLK;
	logic               rst;
	rect_pkg::mb_addr_t host_addr;
	rect_pkg::word_t    host_wdata;
	logic               host_we;
	rect_pkg::word_t    host_rdata;
	wire                fb_we;
	rect_pkg::fb_addr_t fb_addr;
	rect_pkg::color_t   fb_data;

	// Pixels still owed by the current command
	rect_pkg::fb_addr_t exp_addr_q [$];
	rect_pkg::color_t   exp_color_q [$];
	bit                 in_burst;
	logic [15:0]        lfsr_state;

	rect_draw_top dut (
		.iCLK       (iCLK),
		.rst        (rst),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_we    (host_we),
		.host_rdata (host_rdata),
		.fb_we      (fb_we),
		.fb_addr    (fb_addr),
		.fb_data    (fb_data)
	);

	// 100 ns period
	initial begin
		iCLK = 1'b0;
		forever #50 iCLK = ~iCLK;
	end

	// ============================================================
	// Failure reporting and compare tasks
	// ============================================================
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_addr(input string name, input rect_pkg::fb_addr_t exp,
			input rect_pkg::fb_addr_t act);
		if (act !== exp) begin
			report_failure($sformatf("error %s expected 0x%h actual 0x%h", name, exp, act));
		end
	endtask

	task automatic check_color(input string name, input rect_pkg::color_t exp,
			input rect_pkg::color_t act);
		if (act !== exp) begin
			report_failure($sformatf("error %s expected 0x%h actual 0x%h", name, exp, act));
		end
	endtask

	task automatic check_word(input string name, input rect_pkg::word_t exp,
			input rect_pkg::word_t act);
		if (act !== exp) begin
			report_failure($sformatf("error %s expected 0x%h actual 0x%h", name, exp, act));
		end
	endtask

	// ============================================================
	// Pixel model and random colours
	// ============================================================
	// Writes a command needs, from the end rule
	function automatic int pixel_count(input int i);
		int w;
		int h;
		w = (tab_x1[i] <= tab_x2[i]) ? int'(tab_x2[i]) - int'(tab_x1[i]) + 1 : 1;
		h = (tab_y1[i] <= tab_y2[i]) ? int'(tab_y2[i]) - int'(tab_y1[i]) + 1 : 1;
		return w * h;
	endfunction

	// Queue every pixel of the raster walk
	task automatic push_expected(input rect_pkg::coord_t x1, input rect_pkg::coord_t y1,
			input rect_pkg::coord_t x2, input rect_pkg::coord_t y2, input rect_pkg::color_t c);
		int x;
		int y;
		bit last;
		x = int'(x1);
		y = int'(y1);
		last = 1'b0;
		while (!last) begin
			exp_addr_q.push_back(rect_pkg::fb_addr_t'(y * `SCREEN_WIDTH + x));
			exp_color_q.push_back(c);
			if (x >= int'(x2) && y >= int'(y2)) begin
				last = 1'b1;
			end else if (x < int'(x2)) begin
				x = x + 1;
			end else begin
				// Back to the left edge, next row
				x = int'(x1);
				y = y + 1;
			end
		end
	endtask

	// 16-bit Galois LFSR, taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	// One step per colour bit
	task automatic lfsr_color(output rect_pkg::color_t c);
		for (int b = 0; b < `COLOR_W; b++) begin
			lfsr_state = lfsr_step(lfsr_state);
			c[b] = lfsr_state[0];
		end
	endtask

	// ============================================================
	// Host model
	// ============================================================
	// Entered and left 10 ns after a rising edge
	task automatic host_write(input rect_pkg::mb_addr_t a, input rect_pkg::word_t d);
		host_addr  = a;
		host_wdata = d;
		host_we    = 1'b1;
		@(posedge iCLK);
		#10;
		host_we = 1'b0;
	endtask

	// Read data is registered, valid one edge later
	task automatic host_read(input rect_pkg::mb_addr_t a, output rect_pkg::word_t d);
		host_addr = a;
		host_we   = 1'b0;
		@(posedge iCLK);
		#10;
		d = host_rdata;
	endtask

	task automatic run_command(input int i);
		rect_pkg::color_t c;
		rect_pkg::word_t  w [6];
		rect_pkg::word_t  rd;
		c = tab_color[i];
		if (tab_use_lfsr[i]) begin
			lfsr_color(c);
		end
		// Upper bits set so only the low bits count
		w[1] = {22'h2B5A5, tab_x1[i]};
		w[2] = {22'h2B5A5, tab_y1[i]};
		w[3] = {22'h2B5A5, tab_x2[i]};
		w[4] = {22'h2B5A5, tab_y2[i]};
		w[5] = {24'hC3A51E, c};
		for (int k = 1; k <= 5; k++) begin
			host_write(rect_pkg::mb_addr_t'(k), w[k]);
		end
		push_expected(tab_x1[i], tab_y1[i], tab_x2[i], tab_y2[i], c);
		host_write(rect_pkg::mb_addr_t'(`MB_FLAG), rect_pkg::word_t'(32'hF1A60000 + i));

		// Engine clears the flag when done
		do begin
			host_read(rect_pkg::mb_addr_t'(`MB_FLAG), rd);
		end while (rd != '0);
		if (exp_addr_q.size() != 0) begin
			report_failure($sformatf("%0d pixels of command %0d were never written",
				exp_addr_q.size(), i));
		end

		// Parameter words left as the host wrote them
		host_read(rect_pkg::mb_addr_t'(`MB_FLAG), rd);
		check_word("host_rdata word 0", '0, rd);
		for (int k = 1; k <= 5; k++) begin
			host_read(rect_pkg::mb_addr_t'(k), rd);
			check_word($sformatf("host_rdata word %0d", k), w[k], rd);
		end
	endtask

	// ============================================================
	// Frame-buffer monitor
	// ============================================================
	// Outputs settle well before the falling edge
	always @(negedge iCLK) begin
		if (fb_we) begin
			if (exp_addr_q.size() == 0) begin
				report_failure("frame-buffer write while no pixel was expected");
			end else begin
				check_addr("fb_addr", exp_addr_q.pop_front(), fb_addr);
				check_color("fb_data", exp_color_q.pop_front(), fb_data);
				in_burst = (exp_addr_q.size() != 0);
			end
		end else if (in_burst) begin
			report_failure("gap of one cycle in the pixel writes of a rectangle");
		end
	end

	// Watchdog sized from the table
	initial begin : watchdog
		int limit;
		limit = IDLE_CYCLES + 300;
		for (int i = 0; i < NUM_CMDS; i++) begin
			limit = limit + pixel_count(i) + 30;
		end
		repeat (limit) @(posedge iCLK);
		report_failure($sformatf("timeout after %0d cycles, a command never finished", limit));
	end

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		rst        = 1'b1;
		host_addr  = '0;
		host_wdata = '0;
		host_we    = 1'b0;
		in_burst   = 1'b0;
		lfsr_state = 16'd55;

		// Flag word cleared while reset is held
		@(posedge iCLK);
		#10;
		host_write(rect_pkg::mb_addr_t'(`MB_FLAG), '0);
		@(posedge iCLK);
		#10;
		rst = 1'b0;

		// Idle engine, monitor flags any write
		repeat (IDLE_CYCLES) @(posedge iCLK);
		#10;

		for (int i = 0; i < NUM_CMDS; i++) begin
			run_command(i);
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+src
src/rect_pkg.sv
src/cmd_mailbox.sv
src/cmd_sequencer.sv
src/rect_filler.sv
src/rect_draw_top.sv
verif/rect_draw_assert.sv
verif/rect_draw_tb.sv
